//--- Makefile
VERILATOR  := verilator
TOP        := conv_row_fetch_tb
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/buffer_addr_mapper.sv
`timescale 1ns/10ps

module buffer_addr_mapper #(
  parameter int input_buf_adr_log2 = 12,
  parameter int slab_buf_adr_log2  = 13
) (
  input  logic                     clk,
  input  logic                     reset,
  input  conv_cfg_pkg::layer_cfg_t active_cfg,
  input  fetch_pkg::row_loc_t      loc,
  input  logic                     loc_valid,
  output logic                     loc_ready,
  output fetch_pkg::fetch_cmd_t    cmd,
  output logic                     cmd_valid,
  input  logic                     cmd_ready,
  output logic                     layer_done
);

  import conv_cfg_pkg::*;
  import fetch_pkg::*;

  logic [4:0]  nif_shift;
  logic [4:0]  shift_in;
  logic [4:0]  shift_slab;
  logic [4:0]  rows_in_log2;
  logic [4:0]  rows_slab_log2;
  logic [15:0] mask_in;
  logic [15:0] mask_slab;
  logic [15:0] row_base_in;
  logic [15:0] row_base_slab;
  logic [15:0] start_in;
  logic [15:0] start_slab;
  logic [15:0] buf_adr;
  logic [15:0] slab_adr;
  fetch_cmd_t  next_cmd;
  logic        load;
  logic        cmd_fire;

  ////////////////////////////////////////////////////////////
  // shift amounts and row masks
  ////////////////////////////////////////////////////////////

  // words per buffer row, input buffer holds two features per word
  assign nif_shift  = {1'b0, active_cfg.nif_log2} - 5'(ifs_in_row_log2);
  assign shift_in   = nif_shift + {1'b0, active_cfg.ix_log2} - 5'(pixels_in_row_log2);
  assign shift_slab = {1'b0, active_cfg.nif_log2} + {1'b0, active_cfg.ix_log2}
                      - 5'(pixels_in_row_log2);

  // rows that fit in each buffer wrap around
  assign rows_in_log2   = 5'(input_buf_adr_log2) - shift_in;
  assign rows_slab_log2 = 5'(slab_buf_adr_log2) - shift_slab;
  assign mask_in        = 16'hffff >> (5'd16 - rows_in_log2);
  assign mask_slab      = 16'hffff >> (5'd16 - rows_slab_log2);

  ////////////////////////////////////////////////////////////
  // address build
  ////////////////////////////////////////////////////////////

  assign row_base_in   = (loc.row_in_bank & mask_in) << shift_in;
  assign row_base_slab = (loc.row_in_bank & mask_slab) << shift_slab;

  // start offsets, shifted up in 16 bits before the pixel divide
  assign start_in   = 16'(active_cfg.row_start_idx << nif_shift) >> pixels_in_row_log2;
  assign start_slab = 16'(active_cfg.row_slab_start_idx << active_cfg.nif_log2)
                      >> pixels_in_row_log2;

  assign buf_adr  = row_base_in + start_in + (loc.if_idx >> ifs_in_row_log2);
  assign slab_adr = row_base_slab + start_slab + loc.if_idx;

  always_comb begin
    next_cmd.pad      = loc.pad;
    next_cmd.bank     = loc.bank;
    next_cmd.word_sel = loc.if_idx[0];
    next_cmd.last     = loc.last;
    if (loc.pad) begin
      next_cmd.buf_adr  = 16'hffff;
      next_cmd.slab_adr = 16'hffff;
    end else begin
      next_cmd.buf_adr  = buf_adr;
      next_cmd.slab_adr = active_cfg.slab_en ? slab_adr : 16'hffff;
    end
  end

  ////////////////////////////////////////////////////////////
  // stage register and layer end
  ////////////////////////////////////////////////////////////

  assign loc_ready = !cmd_valid || cmd_ready;
  assign load      = loc_valid && loc_ready;
  assign cmd_fire  = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_valid  <= 1'b0;
      layer_done <= 1'b0;
    end else begin
      if (loc_ready) begin
        cmd_valid <= loc_valid;
      end
      // one cycle after the final command leaves
      layer_done <= cmd_fire && cmd.last;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cmd <= next_cmd;
    end
  end

endmodule

//--- hdl/conv_cfg_pkg.sv
package conv_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // buffer geometry
  ////////////////////////////////////////////////////////////

  // rotating row buffers, fixed by the modulo-3 row rotation
  localparam int buffers_num = 3;

  // 32 pixels per buffer row
  localparam int pixels_in_row_log2 = 5;

  // two input features packed per input buffer word
  localparam int ifs_in_row_log2 = 1;

  ////////////////////////////////////////////////////////////
  // layer configuration
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    // vertical stride and padding
    logic [3:0]  stride;
    logic [3:0]  pad;
    // input height and first input row of this pass
    logic [15:0] iy;
    logic [15:0] iy_start;
    // kernel rows to walk
    logic [3:0]  ky_num;
    // log2 of input features and of input width
    logic [3:0]  nif_log2;
    logic [3:0]  ix_log2;
    // row offsets into input and slab storage
    logic [15:0] row_start_idx;
    logic [15:0] row_slab_start_idx;
    logic        slab_en;
  } layer_cfg_t;

endpackage

//--- hdl/conv_row_fetch_top.sv
`timescale 1ns/10ps

module conv_row_fetch_top #(
  parameter int input_buf_adr_log2 = 12,
  parameter int slab_buf_adr_log2  = 13
) (
  input  logic                     clk,
  input  logic                     reset,
  input  conv_cfg_pkg::layer_cfg_t cfg,
  input  logic                     cfg_valid,
  output logic                     cfg_ready,
  output fetch_pkg::fetch_cmd_t    cmd,
  output logic                     cmd_valid,
  input  logic                     cmd_ready
);

  import conv_cfg_pkg::*;
  import fetch_pkg::*;

  layer_cfg_t active_cfg;
  row_req_t   req;
  logic       req_valid;
  logic       req_ready;
  row_loc_t   loc;
  logic       loc_valid;
  logic       loc_ready;
  logic       layer_done;

  ////////////////////////////////////////////////////////////
  // loop walk, row location, address mapping
  ////////////////////////////////////////////////////////////

  fetch_sequencer i_fetch_sequencer (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .cfg_valid  (cfg_valid),
    .cfg_ready  (cfg_ready),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .layer_done (layer_done),
    .active_cfg (active_cfg)
  );

  row_locator i_row_locator (
    .clk        (clk),
    .reset      (reset),
    .active_cfg (active_cfg),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .loc        (loc),
    .loc_valid  (loc_valid),
    .loc_ready  (loc_ready)
  );

  buffer_addr_mapper #(
    .input_buf_adr_log2 (input_buf_adr_log2),
    .slab_buf_adr_log2  (slab_buf_adr_log2)
  ) i_buffer_addr_mapper (
    .clk        (clk),
    .reset      (reset),
    .active_cfg (active_cfg),
    .loc        (loc),
    .loc_valid  (loc_valid),
    .loc_ready  (loc_ready),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .layer_done (layer_done)
  );

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // sequencer to row locator
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    // kernel row within the layer
    logic [3:0]  ky;
    // input-feature word index
    logic [15:0] if_idx;
    // final pair of the layer
    logic        last;
  } row_req_t;

  ////////////////////////////////////////////////////////////
  // row locator to address mapper
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    // row falls in the vertical padding
    logic        pad;
    // which of the rotating row buffers
    logic [1:0]  bank;
    // row position inside that buffer
    logic [15:0] row_in_bank;
    logic [15:0] if_idx;
    logic        last;
  } row_loc_t;

  ////////////////////////////////////////////////////////////
  // fetch command stream
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        pad;
    logic [1:0]  bank;
    // input buffer word address, all ones for padding
    logic [15:0] buf_adr;
    // half-word select within the input buffer word
    logic        word_sel;
    // all ones when padding or slab storage is off
    logic [15:0] slab_adr;
    logic        last;
  } fetch_cmd_t;

endpackage

//--- hdl/fetch_sequencer.sv
`timescale 1ns/10ps

module fetch_sequencer (
  input  logic                     clk,
  input  logic                     reset,
  input  conv_cfg_pkg::layer_cfg_t cfg,
  input  logic                     cfg_valid,
  output logic                     cfg_ready,
  output fetch_pkg::row_req_t      req,
  output logic                     req_valid,
  input  logic                     req_ready,
  input  logic                     layer_done,
  output conv_cfg_pkg::layer_cfg_t active_cfg
);

  import conv_cfg_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_run,
    s_drain
  } state_t;

  state_t     state;
  layer_cfg_t cfg_q;
  logic [3:0] ky_cnt;
  logic [15:0] if_cnt;
  logic       cfg_fire;
  logic       req_fire;
  logic       if_wrap;
  logic       ky_wrap;

  assign cfg_ready = (state == s_idle);
  assign cfg_fire  = cfg_valid && cfg_ready;
  assign req_valid = (state == s_run);
  assign req_fire  = req_valid && req_ready;

  // end of the inner if loop and of the outer ky loop
  assign if_wrap = (if_cnt == ((16'd1 << cfg_q.nif_log2) - 16'd1));
  assign ky_wrap = (ky_cnt == (cfg_q.ky_num - 4'd1));

  ////////////////////////////////////////////////////////////
  // layer state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (cfg_fire) begin
            state <= s_run;
          end
        end
        s_run: begin
          // last request handed over, wait for the command stream to empty
          if (req_fire && if_wrap && ky_wrap) begin
            state <= s_drain;
          end
        end
        s_drain: begin
          if (layer_done) begin
            state <= s_idle;
          end
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  // held for the whole layer, read by both pipeline stages
  always_ff @(posedge clk) begin
    if (cfg_fire) begin
      cfg_q <= cfg;
    end
  end

  ////////////////////////////////////////////////////////////
  // nested loop counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ky_cnt <= '0;
      if_cnt <= '0;
    end else if (cfg_fire) begin
      ky_cnt <= '0;
      if_cnt <= '0;
    end else if (req_fire) begin
      if (if_wrap) begin
        if_cnt <= '0;
        ky_cnt <= ky_cnt + 4'd1;
      end else begin
        if_cnt <= if_cnt + 16'd1;
      end
    end
  end

  assign req.ky     = ky_cnt;
  assign req.if_idx = if_cnt;
  assign req.last   = if_wrap && ky_wrap;

  assign active_cfg = cfg_q;

endmodule

//--- hdl/row_locator.sv
`timescale 1ns/10ps

module row_locator (
  input  logic                     clk,
  input  logic                     reset,
  input  conv_cfg_pkg::layer_cfg_t active_cfg,
  input  fetch_pkg::row_req_t      req,
  input  logic                     req_valid,
  output logic                     req_ready,
  output fetch_pkg::row_loc_t      loc,
  output logic                     loc_valid,
  input  logic                     loc_ready
);

  import conv_cfg_pkg::*;
  import fetch_pkg::*;

  localparam logic [2:0] divisor = 3'(buffers_num);

  logic [15:0] row_pos;
  logic [15:0] pad_lo;
  logic [15:0] pad_hi;
  logic        pad_row;
  logic [15:0] row_idx;
  logic [15:0] row_ofs;
  logic [17:0] quo_rem;
  row_loc_t    next_loc;
  logic        load;

  // restoring division by the buffer count, quotient over remainder
  function automatic logic [17:0] div_by_buffers(input logic [15:0] value);
    logic [2:0]  rem;
    logic [15:0] quo;
    rem = '0;
    quo = '0;
    for (int i = 15; i >= 0; i--) begin
      rem = {rem[1:0], value[i]};
      if (rem >= divisor) begin
        rem    = rem - divisor;
        quo[i] = 1'b1;
      end
    end
    return {quo, rem[1:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // vertical position and padding test
  ////////////////////////////////////////////////////////////

  assign row_pos = {12'b0, req.ky} + active_cfg.iy_start + {12'b0, active_cfg.stride};
  assign pad_lo  = {12'b0, active_cfg.pad} + 16'd1;
  assign pad_hi  = {12'b0, active_cfg.pad} + active_cfg.iy;
  assign pad_row = (row_pos < pad_lo) || (row_pos > pad_hi);

  // row_idx counts from 1 inside the valid input rows
  assign row_idx = row_pos - {12'b0, active_cfg.pad};
  assign row_ofs = row_idx - 16'd1;
  assign quo_rem = div_by_buffers(row_ofs);

  always_comb begin
    next_loc.pad    = pad_row;
    next_loc.if_idx = req.if_idx;
    next_loc.last   = req.last;
    if (pad_row) begin
      next_loc.bank        = 2'd0;
      next_loc.row_in_bank = 16'd0;
    end else begin
      next_loc.bank        = quo_rem[1:0];
      next_loc.row_in_bank = quo_rem[17:2];
    end
  end

  ////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////

  assign req_ready = !loc_valid || loc_ready;
  assign load      = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      loc_valid <= 1'b0;
    end else if (req_ready) begin
      loc_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      loc <= next_loc;
    end
  end

endmodule

//--- tb/conv_row_fetch_assertions.sv
`timescale 1ns/10ps

module conv_row_fetch_assertions (
  input logic                  clk,
  input logic                  reset,
  input logic                  cfg_ready,
  input fetch_pkg::fetch_cmd_t cmd,
  input logic                  cmd_valid,
  input logic                  cmd_ready
);

  // a stalled command keeps its valid and its payload
  property cmd_held_p;
    @(posedge clk) disable iff (reset)
      (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd));
  endproperty

  // no new layer is taken while commands are still out
  property cfg_while_busy_p;
    @(posedge clk) disable iff (reset)
      !(cmd_valid && cfg_ready);
  endproperty

  property reset_clears_cmd_p;
    @(posedge clk) reset |=> !cmd_valid;
  endproperty

  a_cmd_held: assert property (cmd_held_p)
    else $error("command changed or dropped while cmd_ready was low");

  a_cfg_while_busy: assert property (cfg_while_busy_p)
    else $error("cmd_valid and cfg_ready were high together");

  a_reset_clears_cmd: assert property (reset_clears_cmd_p)
    else $error("cmd_valid was high during reset");

endmodule

bind conv_row_fetch_top conv_row_fetch_assertions i_conv_row_fetch_assertions (
  .clk       (clk),
  .reset     (reset),
  .cfg_ready (cfg_ready),
  .cmd       (cmd),
  .cmd_valid (cmd_valid),
  .cmd_ready (cmd_ready)
);

//--- tb/conv_row_fetch_tb.sv
`timescale 1ns/10ps

module conv_row_fetch_tb;

  import conv_cfg_pkg::*;
  import fetch_pkg::*;

  localparam int input_buf_adr_log2 = 12;
  localparam int slab_buf_adr_log2  = 13;
  localparam int layer_count        = 30;
  // clock edges from configuration accept to first command accept
  localparam int first_cmd_latency  = 3;

  logic       clk;
  logic       reset;
  layer_cfg_t cfg;
  logic       cfg_valid;
  logic       cfg_ready;
  fetch_cmd_t cmd;
  logic       cmd_valid;
  logic       cmd_ready;

  layer_cfg_t layers [layer_count];
  fetch_cmd_t expected_q [$];
  int         total_cmds;
  int         cycle_limit;
  int         cycle_count = 0;

  conv_row_fetch_top #(
    .input_buf_adr_log2 (input_buf_adr_log2),
    .slab_buf_adr_log2  (slab_buf_adr_log2)
  ) i_conv_row_fetch_top (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic fetch_cmd_t model_cmd(input layer_cfg_t c, input int ky,
                                           input int if_idx, input bit last);
    fetch_cmd_t m;
    int pos;
    int pad;
    int nif;
    int row_ofs;
    int rows;
    int sh_in;
    int sh_slab;
    int start_in;
    int start_slab;
    pad      = int'(c.pad);
    nif      = int'(c.nif_log2);
    pos      = ky + int'(c.iy_start) + int'(c.stride);
    m.word_sel = 1'(if_idx % 2);
    m.last     = last;
    if ((pos < pad + 1) || (pos > pad + int'(c.iy))) begin
      m.pad      = 1'b1;
      m.bank     = 2'd0;
      m.buf_adr  = 16'hffff;
      m.slab_adr = 16'hffff;
    end else begin
      // rows rotate through the three buffers, counting from row 1
      row_ofs = pos - pad - 1;
      m.pad   = 1'b0;
      m.bank  = 2'(row_ofs % 3);
      rows    = row_ofs / 3;
      sh_in   = nif - ifs_in_row_log2 + int'(c.ix_log2) - pixels_in_row_log2;
      sh_slab = nif + int'(c.ix_log2) - pixels_in_row_log2;
      start_in   = (int'(c.row_start_idx) << (nif - ifs_in_row_log2)) >> pixels_in_row_log2;
      start_slab = (int'(c.row_slab_start_idx) << nif) >> pixels_in_row_log2;
      m.buf_adr  = 16'(((rows % (1 << (input_buf_adr_log2 - sh_in))) << sh_in)
                       + start_in + (if_idx >> ifs_in_row_log2));
      if (c.slab_en) begin
        m.slab_adr = 16'(((rows % (1 << (slab_buf_adr_log2 - sh_slab))) << sh_slab)
                         + start_slab + if_idx);
      end else begin
        m.slab_adr = 16'hffff;
      end
    end
    return m;
  endfunction

  task automatic build_expected(input layer_cfg_t c);
    int words;
    int ky_last;
    words   = 1 << int'(c.nif_log2);
    ky_last = int'(c.ky_num) - 1;
    expected_q.delete();
    for (int ky = 0; ky <= ky_last; ky++) begin
      for (int w = 0; w < words; w++) begin
        expected_q.push_back(model_cmd(c, ky, w, (ky == ky_last) && (w == words - 1)));
      end
    end
  endtask

  // geometry kept so every shift and mask stays in range
  function automatic layer_cfg_t random_layer(input bit edge_rows);
    layer_cfg_t c;
    int nif;
    nif                  = 1 + int'($urandom % 5);
    c.nif_log2           = 4'(nif);
    c.ix_log2            = 4'(6 - nif + int'($urandom % 4));
    c.row_start_idx      = 16'($urandom % 1024);
    c.row_slab_start_idx = 16'($urandom % 1024);
    c.slab_en            = 1'($urandom % 2);
    if (edge_rows) begin
      // small input with a wide pad, rows fall off both edges
      c.stride   = 4'($urandom % 2);
      c.pad      = 4'(2 + $urandom % 2);
      c.iy       = 16'(1 + $urandom % 2);
      c.iy_start = 16'd0;
      c.ky_num   = 4'd8;
    end else begin
      // tall inputs, deep rows wrap the buffer masks
      c.stride   = 4'($urandom % 4);
      c.pad      = 4'($urandom % 4);
      c.iy       = 16'(1 + $urandom % 6000);
      c.iy_start = 16'($urandom % 4000);
      c.ky_num   = 4'(1 + $urandom % 5);
    end
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic string fmt_cmd(input fetch_cmd_t c);
    return $sformatf("{pad %0b bank %0d buf_adr %h word_sel %0b slab_adr %h last %0b}",
                     c.pad, c.bank, c.buf_adr, c.word_sel, c.slab_adr, c.last);
  endfunction

  task automatic check_cmd(input string test, input fetch_cmd_t exp, input fetch_cmd_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %s, actual %s", test, fmt_cmd(exp), fmt_cmd(act));
      abort_run();
    end
  endtask

  task automatic check_cfg_ready(input string test, input bit exp, input bit act);
    if (act !== exp) begin
      $display("[ERROR] %s: cfg_ready expected %0b, actual %0b", test, exp, act);
      abort_run();
    end
  endtask

  task automatic check_latency(input string test, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s: first command after %0d cycles expected, actual %0d",
               test, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one layer, from configuration to cfg_ready again
  ////////////////////////////////////////////////////////////

  task automatic run_layer(input int n);
    fetch_cmd_t exp;
    string      name;
    bit         throttle;
    bit         first_seen;
    int         cycles;
    int         idx;
    build_expected(layers[n]);
    throttle   = (n % 3) != 0;
    first_seen = 1'b0;
    cycles     = 0;
    idx        = 0;
    cfg       <= layers[n];
    cfg_valid <= 1'b1;
    cmd_ready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!cfg_ready);
    cfg_valid <= 1'b0;
    cfg       <= '0;
    while (expected_q.size() > 0) begin
      cmd_ready <= throttle ? 1'(($urandom % 10) >= 3) : 1'b1;
      @(posedge clk);
      cycles++;
      name = $sformatf("layer %0d command %0d", n, idx);
      check_cfg_ready(name, 1'b0, cfg_ready);
      if (cmd_valid && cmd_ready) begin
        if (!first_seen && !throttle) begin
          check_latency(name, first_cmd_latency, cycles);
        end
        first_seen = 1'b1;
        exp = expected_q.pop_front();
        check_cmd(name, exp, cmd);
        idx++;
      end
    end
    // layer_done follows the last command, then the sequencer goes idle
    @(posedge clk);
    check_cfg_ready($sformatf("layer %0d drain", n), 1'b0, cfg_ready);
    if (cmd_valid) begin
      $display("layer %0d: a command came after the last one", n);
      abort_run();
    end
    @(posedge clk);
    check_cfg_ready($sformatf("layer %0d done", n), 1'b1, cfg_ready);
  endtask

  initial begin
    void'($urandom(32'he7b8_c9da));
    reset     <= 1'b1;
    cfg       <= '0;
    cfg_valid <= 1'b0;
    cmd_ready <= 1'b0;
    total_cmds = 0;
    for (int n = 0; n < layer_count; n++) begin
      layers[n]  = random_layer((n % 4) == 1);
      total_cmds += int'(layers[n].ky_num) << int'(layers[n].nif_log2);
    end
    cycle_limit = 4 * total_cmds + 200;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_cfg_ready("after reset", 1'b1, cfg_ready);
    for (int n = 0; n < layer_count; n++) begin
      run_layer(n);
    end
    $display("Test OK");
    $finish;
  end

endmodule

//--- verilog.f
hdl/conv_cfg_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_sequencer.sv
hdl/row_locator.sv
hdl/buffer_addr_mapper.sv
hdl/conv_row_fetch_top.sv
tb/conv_row_fetch_assertions.sv
tb/conv_row_fetch_tb.sv
